// File: common/pc_pkg.sv
package pc_pkg;

   // ==================================================
   // Widths and reset values
   // ==================================================
   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   localparam logic [XLEN-1:0] RESET_PC = 32'd8;

   // ==================================================
   // Command and control types
   // ==================================================
   typedef enum logic [2:0] {
      OP_SEQ,
      OP_JAL,
      OP_JALR,
      OP_BRANCH,
      OP_AUIPC,
      OP_LUI,
      OP_TRAP
   } pc_op_e;

   // One command as presented by the core, 99 bits wide
   typedef struct packed {
      pc_op_e          op;
      logic [XLEN-1:0] offset;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] vector;
   } pc_cmd_t;

   // Decoded control bits for the PC datapath
   typedef struct packed {
      logic jump;
      logic jalr;
      logic jal_or_jalr;
      logic utype;
      logic lui;
      logic trap;
   } pc_flags_t;

endpackage

// File: design/ser_add.sv
`timescale 1ns/10ps

module ser_add (
   input  logic clk,
   input  logic i_rst,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic carry;

   // Sum bit for the current position, carry from the previous one
   assign o_q = i_a ^ i_b ^ carry;

   always_ff @(posedge clk) begin
      if (i_rst || i_clr) begin
         carry <= 1'b0;
      end else begin
         carry <= (i_a & i_b) | (carry & (i_a ^ i_b));
      end
   end

endmodule

// File: design/shift_reg.sv
`timescale 1ns/10ps

module shift_reg #(
   parameter int             LEN  = 32,
   parameter logic [LEN-1:0] INIT = '0
) (
   input  logic           clk,
   input  logic           i_rst,
   input  logic           i_en,
   input  logic           i_d,
   output logic           o_q,
   output logic [LEN-2:0] o_par
);

   logic [LEN-1:0] data;

   // New bits enter at the top, so after LEN shifts the word is in place
   always_ff @(posedge clk) begin
      if (i_rst) begin
         data <= INIT;
      end else if (i_en) begin
         data <= {i_d, data[LEN-1:1]};
      end
   end

   assign o_q   = data[0];
   assign o_par = data[LEN-1:1];

endmodule

// File: design/bit_counter.sv
`timescale 1ns/10ps

module bit_counter
   import pc_pkg::*;
(
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_en,
   output logic [CNT_W-1:0] o_cnt,
   output logic [3:0]       o_cnt_r,
   output logic             o_cnt_done
);

   // ==================================================
   // Bit position and low phase
   // ==================================================

   // The one-hot phase rotates in step with the low two counter bits
   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_cnt   <= '0;
         o_cnt_r <= 4'b0001;
      end else if (i_en) begin
         o_cnt   <= o_cnt + CNT_W'(1);
         o_cnt_r <= {o_cnt_r[2:0], o_cnt_r[3]};
      end
   end

   // Last serial bit, the counter wraps to zero on the following edge
   assign o_cnt_done = &o_cnt;

endmodule

// File: pc_unit/pc_ctrl.sv
`timescale 1ns/10ps

module pc_ctrl
   import pc_pkg::*;
(
   input  logic             clk,
   input  logic             i_rst,
   input  logic             i_en,
   input  logic             i_pc_en,
   input  logic [CNT_W-1:0] i_cnt,
   input  logic [3:0]       i_cnt_r,
   input  logic             i_cnt_done,
   input  pc_flags_t        i_flags,
   input  logic             i_offset,
   input  logic             i_rs1,
   input  logic             i_csr_pc,
   output logic             o_rd,
   output logic             o_misalign,
   output logic [XLEN-1:0]  o_ibus_adr,
   output logic             o_ibus_cyc,
   input  logic             i_ibus_ack
);

   logic            pc_bit;
   logic [XLEN-2:0] pc_upper;
   logic            plus_4;
   logic            pc_plus_4;
   logic            offset_a;
   logic            target;
   logic            lsb;
   logic            new_pc;
   logic            fetch_pend;
   logic            add_clr;

   // ==================================================
   // Serial adders
   // ==================================================
   assign lsb     = (i_cnt == '0);
   assign plus_4  = i_cnt_r[2] & (i_cnt[CNT_W-1:2] == '0);
   assign add_clr = !i_en | i_cnt_done;

   ser_add add_pc_plus_4 (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (pc_bit),
      .i_b   (plus_4),
      .i_clr (add_clr),
      .o_q   (pc_plus_4)
   );

   // Base of the target is rs1 for JALR and the current PC otherwise
   assign offset_a = i_flags.jalr ? i_rs1 : pc_bit;

   ser_add add_target (
      .clk   (clk),
      .i_rst (i_rst),
      .i_a   (offset_a),
      .i_b   (i_offset),
      .i_clr (add_clr),
      .o_q   (target)
   );

   // ==================================================
   // PC register and results
   // ==================================================
   assign new_pc = !lsb & (i_flags.trap ? i_csr_pc :
                           i_flags.jump ? target : pc_plus_4);

   shift_reg #(
      .LEN  (XLEN),
      .INIT (RESET_PC)
   ) pc_reg (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (i_pc_en),
      .i_d   (new_pc),
      .o_q   (pc_bit),
      .o_par (pc_upper)
   );

   assign o_ibus_adr = {pc_upper, pc_bit};

   // LUI passes the immediate straight through, AUIPC takes the sum
   assign o_rd = (i_flags.utype & (i_flags.lui ? i_offset : target)) |
                 (i_flags.jal_or_jalr & pc_plus_4);

   // A fetch is owed from the last bit of every run until it is acknowledged
   always_ff @(posedge clk) begin
      if (i_rst) begin
         fetch_pend <= 1'b1;
         o_misalign <= 1'b0;
      end else begin
         if (i_pc_en && i_cnt_done) begin
            fetch_pend <= 1'b1;
         end else if (o_ibus_cyc && i_ibus_ack) begin
            fetch_pend <= 1'b0;
         end
         if (i_en && i_cnt_r[1] && (i_cnt[CNT_W-1:2] == '0)) begin
            o_misalign <= target;
         end
      end
   end

   assign o_ibus_cyc = fetch_pend;

endmodule

// File: pc_unit/pc_sequencer.sv
`timescale 1ns/10ps

module pc_sequencer
   import pc_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst,
   input  logic      i_start,
   input  pc_op_e    i_op,
   input  logic      i_cnt_done,
   input  logic      i_fetch_busy,
   output pc_flags_t o_flags,
   output logic      o_pc_en,
   output logic      o_cnt_en,
   output logic      o_load,
   output logic      o_ready,
   output logic      o_done
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_RUN,
      S_DONE
   } state_e;

   state_e state;
   pc_op_e op_q;

   // ==================================================
   // Control FSM
   // ==================================================
   assign o_ready = (state == S_IDLE) & !i_fetch_busy;
   assign o_load  = i_start & o_ready;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= S_IDLE;
         op_q  <= OP_SEQ;
      end else begin
         case (state)
            S_IDLE: begin
               if (o_load) begin
                  op_q  <= i_op;
                  state <= S_RUN;
               end
            end
            S_RUN: begin
               if (i_cnt_done) begin
                  state <= S_DONE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   assign o_pc_en  = (state == S_RUN);
   assign o_cnt_en = (state == S_RUN);
   assign o_done   = (state == S_DONE);

   // Operation decode for the datapath
   always_comb begin
      o_flags = '0;
      case (op_q)
         OP_JAL:    {o_flags.jump, o_flags.jal_or_jalr} = 2'b11;
         OP_JALR:   {o_flags.jump, o_flags.jalr, o_flags.jal_or_jalr} = 3'b111;
         OP_BRANCH: o_flags.jump = 1'b1;
         OP_AUIPC:  o_flags.utype = 1'b1;
         OP_LUI:    {o_flags.utype, o_flags.lui} = 2'b11;
         OP_TRAP:   o_flags.trap = 1'b1;
         default:   o_flags = '0;
      endcase
   end

endmodule

// File: design/operand_serializer.sv
`timescale 1ns/10ps

module operand_serializer
   import pc_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_load,
   input  logic            i_shift,
   input  pc_cmd_t         i_cmd,
   input  logic            i_rd_bit,
   output logic            o_offset_bit,
   output logic            o_rs1_bit,
   output logic            o_vector_bit,
   output logic [XLEN-1:0] o_rd
);

   logic [XLEN-1:0] offset_q;
   logic [XLEN-1:0] rs1_q;
   logic [XLEN-1:0] vector_q;
   logic            rd_lsb;
   logic [XLEN-2:0] rd_upper;
   logic [XLEN-1:0] rd_live;
   logic [XLEN-1:0] rd_hold;

   // ==================================================
   // Operand words, shifted out LSB-first
   // ==================================================
   always_ff @(posedge clk) begin
      if (i_load) begin
         offset_q <= i_cmd.offset;
         rs1_q    <= i_cmd.rs1;
         vector_q <= i_cmd.vector;
      end else if (i_shift) begin
         offset_q <= {1'b0, offset_q[XLEN-1:1]};
         rs1_q    <= {1'b0, rs1_q[XLEN-1:1]};
         vector_q <= {1'b0, vector_q[XLEN-1:1]};
      end
   end

   assign o_offset_bit = offset_q[0];
   assign o_rs1_bit    = rs1_q[0];
   assign o_vector_bit = vector_q[0];

   // ==================================================
   // Result collection
   // ==================================================
   shift_reg #(
      .LEN  (XLEN),
      .INIT ({XLEN{1'b0}})
   ) rd_reg (
      .clk   (clk),
      .i_rst (i_rst),
      .i_en  (i_shift),
      .i_d   (i_rd_bit),
      .o_q   (rd_lsb),
      .o_par (rd_upper)
   );

   assign rd_live = {rd_upper, rd_lsb};

   // Keep showing the previous result while a new one is being shifted in
   always_ff @(posedge clk) begin
      if (!i_shift) begin
         rd_hold <= rd_live;
      end
   end

   assign o_rd = i_shift ? rd_hold : rd_live;

endmodule

// File: design/serial_pc_top.sv
`timescale 1ns/10ps

module serial_pc_top
   import pc_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_start,
   input  pc_cmd_t         i_cmd,
   input  logic            i_ibus_ack,
   output logic            o_ready,
   output logic            o_done,
   output logic [XLEN-1:0] o_rd,
   output logic            o_misalign,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ibus_cyc
);

   pc_flags_t        flags;
   logic             pc_en;
   logic             cnt_en;
   logic             load;
   logic [CNT_W-1:0] cnt;
   logic [3:0]       cnt_r;
   logic             cnt_done;
   logic             offset_bit;
   logic             rs1_bit;
   logic             vector_bit;
   logic             rd_bit;

   // ==================================================
   // Control
   // ==================================================
   pc_sequencer seq_i (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_start      (i_start),
      .i_op         (i_cmd.op),
      .i_cnt_done   (cnt_done),
      .i_fetch_busy (o_ibus_cyc),
      .o_flags      (flags),
      .o_pc_en      (pc_en),
      .o_cnt_en     (cnt_en),
      .o_load       (load),
      .o_ready      (o_ready),
      .o_done       (o_done)
   );

   bit_counter cnt_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_en       (cnt_en),
      .o_cnt      (cnt),
      .o_cnt_r    (cnt_r),
      .o_cnt_done (cnt_done)
   );

   // ==================================================
   // Datapath
   // ==================================================
   operand_serializer ser_i (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_load       (load),
      .i_shift      (pc_en),
      .i_cmd        (i_cmd),
      .i_rd_bit     (rd_bit),
      .o_offset_bit (offset_bit),
      .o_rs1_bit    (rs1_bit),
      .o_vector_bit (vector_bit),
      .o_rd         (o_rd)
   );

   pc_ctrl ctrl_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_en       (cnt_en),
      .i_pc_en    (pc_en),
      .i_cnt      (cnt),
      .i_cnt_r    (cnt_r),
      .i_cnt_done (cnt_done),
      .i_flags    (flags),
      .i_offset   (offset_bit),
      .i_rs1      (rs1_bit),
      .i_csr_pc   (vector_bit),
      .o_rd       (rd_bit),
      .o_misalign (o_misalign),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack)
   );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
   parameter int PERIOD_NS = 4
) (
   output logic o_clk
);

   // Free-running clock, low for the first half period
   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) o_clk = ~o_clk;
      end
   end

endmodule

// File: test/serial_pc_assertions.sv
`timescale 1ns/10ps

module serial_pc_assertions
   import pc_pkg::*;
(
   input logic            clk,
   input logic            i_rst,
   input logic            pc_en,
   input logic            o_done,
   input logic            o_ibus_cyc,
   input logic [XLEN-1:0] o_ibus_adr
);

   // ==================================================
   // Control properties of the top level
   // ==================================================

   // The PC register is in flux during a run, so no fetch may be requested then
   fetch_outside_run: assert property (@(posedge clk) disable iff (i_rst)
      !(o_ibus_cyc && pc_en))
      else $error("Fetch request raised while the PC is shifting");

   done_one_cycle: assert property (@(posedge clk) disable iff (i_rst)
      o_done |=> !o_done)
      else $error("Done pulse longer than one cycle");

   fetch_aligned: assert property (@(posedge clk) disable iff (i_rst)
      o_ibus_cyc |-> !o_ibus_adr[0])
      else $error("Fetch address has bit 0 set");

endmodule

// File: test/serial_pc_tb.sv
`timescale 1ns/10ps

module serial_pc_tb
   import pc_pkg::*;
();

   localparam int          N_ENTRIES     = 14;
   localparam int          RANDOM_CMDS   = 200;
   localparam int          DONE_CYCLES   = 33;
   localparam int          DONE_TIMEOUT  = 40;
   localparam int          READY_TIMEOUT = 20;
   localparam int          POKE_CYCLE    = 10;
   localparam int unsigned SEED          = 32'h099c29a5;

   typedef struct packed {
      pc_op_e          op;
      logic [XLEN-1:0] offset;
      logic [XLEN-1:0] rs1;
      logic [XLEN-1:0] vector;
      logic [XLEN-1:0] exp_pc;
      logic [XLEN-1:0] exp_rd;
      logic            exp_mis;
   } entry_t;

   // Each row starts from the PC that the row above leaves behind, the first from RESET_PC
   entry_t cmd_table [N_ENTRIES] = '{
      '{OP_SEQ,    32'h00000010, 32'h00000000, 32'h00000000, 32'h0000000c, 32'h0, 1'b0},
      '{OP_BRANCH, 32'h00000020, 32'h00000000, 32'h00000000, 32'h0000002c, 32'h0, 1'b0},
      '{OP_JAL,    32'h00000102, 32'h00000000, 32'h00000000, 32'h0000012e, 32'h30, 1'b1},
      '{OP_JALR,   32'h00000007, 32'h00001000, 32'h00000000, 32'h00001006, 32'h132, 1'b1},
      '{OP_AUIPC,  32'h12345000, 32'h00000000, 32'h00000000, 32'h0000100a, 32'h12346006, 1'b1},
      '{OP_LUI,    32'habcde000, 32'h00000000, 32'h00000000, 32'h0000100e, 32'habcde000, 1'b1},
      '{OP_TRAP,   32'h00000004, 32'h00000000, 32'h80000101, 32'h80000100, 32'h0, 1'b1},
      '{OP_BRANCH, 32'hfffffff0, 32'h00000000, 32'h00000000, 32'h800000f0, 32'h0, 1'b0},
      '{OP_JALR,   32'hffffffff, 32'h00000200, 32'h00000000, 32'h000001fe, 32'h800000f4, 1'b1},
      '{OP_SEQ,    32'h00000000, 32'h00000000, 32'h00000000, 32'h00000202, 32'h0, 1'b1},
      '{OP_JAL,    32'hfffffe00, 32'h00000000, 32'h00000000, 32'h00000002, 32'h206, 1'b1},
      '{OP_TRAP,   32'h00000000, 32'h00000000, 32'h00000008, 32'h00000008, 32'h0, 1'b1},
      '{OP_TRAP,   32'h00000000, 32'h00000000, 32'hfffffffd, 32'hfffffffc, 32'h0, 1'b0},
      '{OP_JAL,    32'h00000008, 32'h00000000, 32'h00000000, 32'h00000004, 32'h0, 1'b0}
   };

   logic            clk;
   logic            i_rst;
   logic            i_start;
   pc_cmd_t         i_cmd;
   logic            i_ibus_ack;
   logic            o_ready;
   logic            o_done;
   logic [XLEN-1:0] o_rd;
   logic            o_misalign;
   logic [XLEN-1:0] o_ibus_adr;
   logic            o_ibus_cyc;

   tb_clock #(.PERIOD_NS (4)) clk_i (
      .o_clk (clk)
   );

   serial_pc_top dut_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_start    (i_start),
      .i_cmd      (i_cmd),
      .i_ibus_ack (i_ibus_ack),
      .o_ready    (o_ready),
      .o_done     (o_done),
      .o_rd       (o_rd),
      .o_misalign (o_misalign),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc)
   );

   bind serial_pc_top serial_pc_assertions assert_i (
      .clk        (clk),
      .i_rst      (i_rst),
      .pc_en      (pc_en),
      .o_done     (o_done),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr)
   );

   // ==================================================
   // Checking and reference model
   // ==================================================
   task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s expected %h actual %h", name, expected, actual);
         $display("Checks failed");
         $fatal(1, "Run stopped at first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out waiting for %s", what);
      $display("Checks failed");
      $fatal(1, "Run stopped on timeout");
   endtask

   // Next PC, rd and misalignment of one command, straight from the operation rules
   function automatic void predict(input pc_cmd_t cmd, input logic [XLEN-1:0] pc,
                                   output logic [XLEN-1:0] next_pc,
                                   output logic [XLEN-1:0] rd, output logic mis);
      logic [XLEN-1:0] target;
      target  = ((cmd.op == OP_JALR) ? cmd.rs1 : pc) + cmd.offset;
      mis     = target[1];
      rd      = '0;
      next_pc = pc + 32'd4;
      case (cmd.op)
         OP_JAL, OP_JALR: begin
            next_pc = target;
            rd      = pc + 32'd4;
         end
         OP_BRANCH: next_pc = target;
         OP_AUIPC:  rd = pc + cmd.offset;
         OP_LUI:    rd = cmd.offset;
         OP_TRAP:   next_pc = cmd.vector;
         default:   rd = '0;
      endcase
      next_pc[0] = 1'b0;
   endfunction

   // ==================================================
   // Bus and command tasks
   // ==================================================
   task automatic wait_for_ready(input string name);
      int waited;
      waited = 0;
      while (!o_ready) begin
         if (waited >= READY_TIMEOUT) begin
            report_timeout({name, " ready"});
         end
         @(negedge clk);
         waited++;
      end
   endtask

   // Hold off the acknowledge for a while, with a start pulse that must be ignored
   task automatic acknowledge_fetch(input string name, input int unsigned delay,
                                    input logic [XLEN-1:0] exp_pc);
      repeat (delay) begin
         check_value({name, " cyc held"}, 32'd1, 32'(o_ibus_cyc));
         check_value({name, " adr held"}, exp_pc, o_ibus_adr);
         @(negedge clk);
      end
      check_value({name, " adr"}, exp_pc, o_ibus_adr);
      i_ibus_ack = 1'b1;
      i_start    = 1'b1;
      @(negedge clk);
      i_ibus_ack = 1'b0;
      i_start    = 1'b0;
      check_value({name, " cyc dropped"}, 32'd0, 32'(o_ibus_cyc));
      check_value({name, " ready after ack"}, 32'd1, 32'(o_ready));
   endtask

   task automatic run_command(input string name, input pc_cmd_t cmd,
                              input logic [XLEN-1:0] exp_pc, input logic [XLEN-1:0] exp_rd,
                              input logic exp_mis, input int unsigned ack_delay);
      int      cycles;
      pc_cmd_t junk;
      junk        = cmd;
      junk.op     = OP_TRAP;
      junk.offset = ~cmd.offset;
      junk.rs1    = ~cmd.rs1;
      junk.vector = ~cmd.vector;
      wait_for_ready(name);
      i_cmd   = cmd;
      i_start = 1'b1;
      cycles  = 0;
      while (!o_done) begin
         if (cycles >= DONE_TIMEOUT) begin
            report_timeout({name, " done"});
         end
         @(negedge clk);
         cycles++;
         i_start = (cycles == POKE_CYCLE);
         if (cycles == POKE_CYCLE) begin
            i_cmd = junk;
         end
         if (cycles == 1) begin
            check_value({name, " ready in run"}, 32'd0, 32'(o_ready));
         end
      end
      check_value({name, " latency"}, DONE_CYCLES, cycles);
      check_value({name, " cyc"}, 32'd1, 32'(o_ibus_cyc));
      check_value({name, " pc"}, exp_pc, o_ibus_adr);
      check_value({name, " rd"}, exp_rd, o_rd);
      check_value({name, " misalign"}, 32'(exp_mis), 32'(o_misalign));
      acknowledge_fetch(name, ack_delay, exp_pc);
      check_value({name, " rd kept"}, exp_rd, o_rd);
   endtask

   // ==================================================
   // Test sequence
   // ==================================================
   initial begin
      pc_cmd_t         cmd;
      pc_op_e          op;
      entry_t          entry;
      logic [XLEN-1:0] model_pc;
      logic [XLEN-1:0] exp_pc;
      logic [XLEN-1:0] exp_rd;
      logic            exp_mis;

      void'($urandom(SEED));
      i_rst      = 1'b1;
      i_start    = 1'b0;
      i_cmd      = '0;
      i_ibus_ack = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;
      @(negedge clk);

      // Out of reset the unit fetches from RESET_PC before taking commands
      check_value("reset cyc", 32'd1, 32'(o_ibus_cyc));
      check_value("reset ready", 32'd0, 32'(o_ready));
      check_value("reset done", 32'd0, 32'(o_done));
      check_value("reset misalign", 32'd0, 32'(o_misalign));
      acknowledge_fetch("reset", 2, RESET_PC);

      for (int i = 0; i < N_ENTRIES; i++) begin
         entry      = cmd_table[i];
         op         = entry.op;
         cmd.op     = entry.op;
         cmd.offset = entry.offset;
         cmd.rs1    = entry.rs1;
         cmd.vector = entry.vector;
         run_command($sformatf("table %0d %s", i, op.name()), cmd, entry.exp_pc,
                     entry.exp_rd, entry.exp_mis, $urandom_range(0, 4));
      end

      model_pc = cmd_table[N_ENTRIES-1].exp_pc;
      for (int n = 0; n < RANDOM_CMDS; n++) begin
         op         = pc_op_e'(3'($urandom_range(0, 6)));
         cmd.op     = op;
         cmd.offset = $urandom();
         cmd.rs1    = $urandom();
         cmd.vector = $urandom();
         predict(cmd, model_pc, exp_pc, exp_rd, exp_mis);
         run_command($sformatf("random %0d %s", n, op.name()), cmd, exp_pc, exp_rd,
                     exp_mis, $urandom_range(0, 6));
         model_pc = exp_pc;
      end

      $display("All checks passed");
      $finish;
   end

endmodule

// File: sim.f
common/pc_pkg.sv
design/ser_add.sv
design/shift_reg.sv
design/bit_counter.sv
pc_unit/pc_ctrl.sv
pc_unit/pc_sequencer.sv
design/operand_serializer.sv
design/serial_pc_top.sv
test/tb_clock.sv
test/serial_pc_assertions.sv
test/serial_pc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the serial PC testbench with Verilator and runs it.
# The exit status is that of the failing step, or 0 when all is well.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module serial_pc_tb \
   -Mdir obj_dir -o serial_pc_sim \
   -f sim.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/serial_pc_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0
